// File: Makefile
VERILATOR  ?= verilator
TOP        := decode_stage_tb
FILELIST   := all.f
BUILD      := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := Done: no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// File: all.f
+incdir+sim
source/decode_pkg.sv
source/instr_decoder.sv
source/operand_builder.sv
source/issue_register.sv
source/decode_stage.sv
sim/decode_stage_tb.sv

// File: sim/decode_model.svh
//////////////////////////////
// Reference decode model
// Immediates, target unit,
// ALU op and ALU port values
//////////////////////////////

`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

function automatic word_t imm_i_of(input word_t w);
  return {{20{w[31]}}, w[31:20]};
endfunction

function automatic word_t imm_s_of(input word_t w);
  return {{20{w[31]}}, w[31:25], w[11:7]};
endfunction

function automatic word_t imm_u_of(input word_t w);
  return {w[31:12], 12'd0};
endfunction

function automatic word_t imm_j_of(input word_t w);
  return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
endfunction

// 0 none, 1 arith, 2 muldiv, 3 load/store
function automatic int unit_of(input word_t w);
  case (w[6:0])
    OP:                             return (w[31:25] == 7'h01) ? 2 : 1;
    OP_IMM, LUI, AUIPC, JAL, JALR:  return 1;
    LOAD, STORE:                    return 3;
    default:                        return 0;
  endcase
endfunction

function automatic logic [3:0] alu_op_of(input word_t w);
  logic [2:0] f3;
  f3 = w[14:12];
  if (w[6:0] != OP && w[6:0] != OP_IMM) begin
    return ADD;
  end
  // Bit 30 picks SRA for both shift forms, SUB only for OP
  if (f3 == 3'd5) begin
    return w[30] ? SRA : SRL;
  end
  if (f3 == 3'd0 && w[6:0] == OP && w[30]) begin
    return SUB;
  end
  return {1'b0, f3};
endfunction

function automatic word_t port_a_of(input word_t w, input word_t pc_v, input word_t r1);
  case (w[6:0])
    LUI:        return 32'd0;
    AUIPC, JAL: return pc_v;
    default:    return r1;
  endcase
endfunction

function automatic word_t port_b_of(input word_t w, input word_t r2);
  case (w[6:0])
    OP:         return r2;
    LUI, AUIPC: return imm_u_of(w);
    JAL:        return imm_j_of(w);
    default:    return imm_i_of(w);
  endcase
endfunction

`endif

// File: sim/decode_stage_tb.sv
//////////////////////////////
// Decode stage testbench
// Clock, reset, random stimulus,
// register file model and checks
//////////////////////////////

module decode_stage_tb import decode_pkg::*; ();

  `include "decode_model.svh"

  logic     CLK;
  logic     nRST;
  word_t    instr;
  word_t    pc;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     pc_en;
  logic     flush;
  logic     stall_arith;
  logic     stall_muldiv;
  logic     stall_ls;
  reg_idx_t rs1;
  reg_idx_t rs2;
  logic     arith_start;
  alu_op_t  arith_op;
  word_t    arith_a;
  word_t    arith_b;
  logic     arith_jump;
  word_t    arith_j_base;
  word_t    arith_j_offset;
  word_t    arith_link;
  logic     arith_wen;
  reg_idx_t arith_rd;
  logic     md_start;
  md_op_t   md_op;
  word_t    md_a;
  word_t    md_b;
  reg_idx_t md_rd;
  logic     ls_start;
  mem_op_t  ls_op;
  word_t    ls_base;
  word_t    ls_offset;
  word_t    ls_store_data;
  reg_idx_t ls_rd;

  // Expected issue register contents
  // The known flags are low while a payload is a don't care
  logic       ea_start;
  logic       ea_known;
  logic [3:0] ea_op;
  word_t      ea_a;
  word_t      ea_b;
  logic       ea_jump;
  word_t      ea_base;
  word_t      ea_off;
  word_t      ea_link;
  logic       ea_wen;
  reg_idx_t   ea_rd;
  logic       em_start;
  logic       em_known;
  logic [2:0] em_op;
  word_t      em_a;
  word_t      em_b;
  reg_idx_t   em_rd;
  logic       el_start;
  logic       el_known;
  logic [3:0] el_op;
  word_t      el_base;
  word_t      el_off;
  word_t      el_data;
  reg_idx_t   el_rd;

  word_t regs [32];
  int    seed;
  int    checks;
  int    errors;
  int    test_errs;
  int    tests_run;
  int    tests_failed;
  int    wait_cycles;

  decode_stage decode_stage_i (.*);

  // Register file answers in the same cycle
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always #50 CLK = ~CLK;

  // Kind 0 arith, 1 jump, 2 muldiv, 3 load/store, 4 unknown, 5 any
  task automatic make_instr(input int kind, output word_t w);
    int k;
    int pick;
    w    = $random(seed);
    k    = (kind == 5) ? $unsigned($random(seed)) % 5 : kind;
    pick = $unsigned($random(seed)) % 5;
    case (k)
      0: begin
        w[6:0] = (pick == 0) ? OP : (pick == 1) ? OP_IMM : (pick == 2) ? LUI : AUIPC;
        // Only bit 30 of funct7 is meaningful here
        if (w[6:0] == OP || w[14:12] == 3'd5) begin
          w[31:25] = {1'b0, w[30], 5'd0};
        end
      end
      1: w[6:0] = w[7] ? JAL : JALR;
      2: begin
        w[6:0]   = OP;
        w[31:25] = 7'h01;
      end
      3: begin
        if (w[7]) begin
          w[6:0]   = STORE;
          w[14:12] = 3'(pick % 3);
        end else begin
          // LB, LH, LW, LBU, LHU
          w[6:0]   = LOAD;
          w[14:12] = (pick > 2) ? 3'(pick + 1) : 3'(pick);
        end
      end
      // Branch or system opcode
      default: w[6:0] = w[7] ? 7'b1100011 : 7'b1110011;
    endcase
  endtask

  task automatic update_arith(input logic clear, input word_t w, input word_t pc_v,
                              input word_t r1, input word_t r2);
    if (clear) begin
      {ea_start, ea_op, ea_a, ea_b, ea_jump, ea_base, ea_off, ea_link, ea_wen, ea_rd} = '0;
      ea_known = 1'b1;
    end else begin
      ea_start = unit_of(w) == 1;
      ea_known = ea_start;
      ea_op    = alu_op_of(w);
      ea_a     = port_a_of(w, pc_v, r1);
      ea_b     = port_b_of(w, r2);
      ea_jump  = (w[6:0] == JAL) || (w[6:0] == JALR);
      // JALR jumps from rs1 with the I immediate, JAL from the PC
      ea_base  = (w[6:0] == JALR) ? r1 : pc_v;
      ea_off   = (w[6:0] == JALR) ? imm_i_of(w) : imm_j_of(w);
      ea_link  = pc_v + 32'd4;
      ea_wen   = 1'b1;
      ea_rd    = w[11:7];
    end
  endtask

  task automatic update_md(input logic clear, input word_t w, input word_t r1, input word_t r2);
    if (clear) begin
      {em_start, em_op, em_a, em_b, em_rd} = '0;
      em_known = 1'b1;
    end else begin
      em_start = unit_of(w) == 2;
      em_known = em_start;
      em_op    = w[14:12];
      em_a     = r1;
      em_b     = r2;
      em_rd    = w[11:7];
    end
  endtask

  task automatic update_ls(input logic clear, input word_t w, input word_t r1, input word_t r2);
    if (clear) begin
      {el_start, el_op, el_base, el_off, el_data, el_rd} = '0;
      el_known = 1'b1;
    end else begin
      el_start = unit_of(w) == 3;
      el_known = el_start;
      // Store kinds carry no register write
      if (w[6:0] == STORE) begin
        case (w[14:12])
          3'd0:    el_op = SB;
          3'd1:    el_op = SH;
          default: el_op = SW;
        endcase
      end else begin
        case (w[14:12])
          3'd0:    el_op = LB;
          3'd1:    el_op = LH;
          3'd2:    el_op = LW;
          3'd4:    el_op = LBU;
          default: el_op = LHU;
        endcase
      end
      el_base  = r1;
      el_off   = (w[6:0] == STORE) ? imm_s_of(w) : imm_i_of(w);
      el_data  = r2;
      el_rd    = w[11:7];
    end
  endtask

  task automatic drive_cycle(input int kind, input logic use_ctrl);
    word_t w;
    word_t r1;
    word_t r2;
    make_instr(kind, w);
    instr        = w;
    pc           = $random(seed) & 32'hFFFF_FFFC;
    pc_en        = !use_ctrl || ($unsigned($random(seed)) % 4 != 0);
    flush        = use_ctrl && ($unsigned($random(seed)) % 10 == 0);
    stall_arith  = use_ctrl && ($unsigned($random(seed)) % 6 == 0);
    stall_muldiv = use_ctrl && ($unsigned($random(seed)) % 6 == 0);
    stall_ls     = use_ctrl && ($unsigned($random(seed)) % 6 == 0);
    r1 = regs[w[19:15]];
    r2 = regs[w[24:20]];
    // Nothing changes at the next edge while pc_en is low
    if (pc_en) begin
      update_arith(flush || stall_arith, w, pc, r1, r2);
      update_md(flush || stall_muldiv, w, r1, r2);
      update_ls(flush || stall_ls, w, r1, r2);
    end
  endtask

  task automatic compare_field(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      test_errs++;
      $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_outputs();
    // Register file indices follow the current instruction
    compare_field("rs1", 32'(rs1), 32'(instr[19:15]));
    compare_field("rs2", 32'(rs2), 32'(instr[24:20]));
    compare_field("arith_start", 32'(arith_start), 32'(ea_start));
    compare_field("md_start", 32'(md_start), 32'(em_start));
    compare_field("ls_start", 32'(ls_start), 32'(el_start));
    if (ea_known) begin
      compare_field("arith_op", 32'(arith_op), 32'(ea_op));
      compare_field("arith_a", arith_a, ea_a);
      compare_field("arith_b", arith_b, ea_b);
      compare_field("arith_jump", 32'(arith_jump), 32'(ea_jump));
      compare_field("arith_link", arith_link, ea_link);
      compare_field("arith_wen", 32'(arith_wen), 32'(ea_wen));
      compare_field("arith_rd", 32'(arith_rd), 32'(ea_rd));
      // Jump fields only mean something for jumps and bubbles
      if (ea_jump || !ea_start) begin
        compare_field("arith_j_base", arith_j_base, ea_base);
        compare_field("arith_j_offset", arith_j_offset, ea_off);
      end
    end
    if (em_known) begin
      compare_field("md_op", 32'(md_op), 32'(em_op));
      compare_field("md_a", md_a, em_a);
      compare_field("md_b", md_b, em_b);
      compare_field("md_rd", 32'(md_rd), 32'(em_rd));
    end
    if (el_known) begin
      compare_field("ls_op", 32'(ls_op), 32'(el_op));
      compare_field("ls_base", ls_base, el_base);
      compare_field("ls_offset", ls_offset, el_off);
      compare_field("ls_store_data", ls_store_data, el_data);
      compare_field("ls_rd", 32'(ls_rd), 32'(el_rd));
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    errors += test_errs;
    if (test_errs == 0) begin
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  // Starts and ends 1 unit after a rising edge
  task automatic run_test(input string name, input int kind, input logic use_ctrl, input int n);
    repeat (n) begin
      #4;
      drive_cycle(kind, use_ctrl);
      @(posedge CLK);
      #1;
      check_outputs();
    end
    report_test(name);
  endtask

  // Reset held for 8 cycles
  initial begin
    nRST = 1'b0;
    repeat (8) @(posedge CLK);
    #5;
    nRST = 1'b1;
  end

  // Upper bound on the whole run
  initial begin
    #(100 * 3000);
    $display("Simulation stopped, cycle limit reached");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    seed         = 38018;
    CLK          = 1'b0;
    instr        = '0;
    pc           = '0;
    pc_en        = 1'b0;
    flush        = 1'b0;
    stall_arith  = 1'b0;
    stall_muldiv = 1'b0;
    stall_ls     = 1'b0;
    checks       = 0;
    errors       = 0;
    test_errs    = 0;
    tests_run    = 0;
    tests_failed = 0;
    wait_cycles  = 0;
    for (int i = 0; i < 32; i++) begin
      regs[i] = (i == 0) ? 32'd0 : $random(seed);
    end
    update_arith(1'b1, '0, '0, '0, '0);
    update_md(1'b1, '0, '0, '0);
    update_ls(1'b1, '0, '0, '0);

    while (nRST !== 1'b1) begin
      @(posedge CLK);
      wait_cycles++;
      if (wait_cycles > 20) begin
        $display("Reset was not released within %0d cycles", wait_cycles);
        $display("Done: errors found");
        $finish;
      end
    end
    #1;
    check_outputs();
    report_test("reset");

    run_test("arith", 0, 1'b0, 200);
    run_test("unknown opcode", 4, 1'b0, 50);
    run_test("jump", 1, 1'b0, 200);
    run_test("muldiv", 2, 1'b0, 200);
    run_test("load/store", 3, 1'b0, 200);
    run_test("pipeline control", 5, 1'b1, 400);

    $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: source/decode_pkg.sv
//////////////////////////////
// Shared decode definitions
// Word and index types, opcodes
// Unit and operation encodings
// Issue payload widths
//////////////////////////////

package decode_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // RV32 major opcodes handled by this stage
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_t;

  typedef enum logic [1:0] {
    FU_NONE,
    FU_ARITH,
    FU_MULDIV,
    FU_LS
  } fu_t;

  // Encoded as {instr[30], funct3}
  typedef enum logic [3:0] {
    ADD  = 4'b0000,
    SLL  = 4'b0001,
    SLT  = 4'b0010,
    SLTU = 4'b0011,
    XOR  = 4'b0100,
    SRL  = 4'b0101,
    OR   = 4'b0110,
    AND  = 4'b0111,
    SUB  = 4'b1000,
    SRA  = 4'b1101
  } alu_op_t;

  // Same values as funct3
  typedef enum logic [2:0] {
    MUL, MULH, MULHSU, MULHU,
    DIV, DIVU, REM, REMU
  } md_op_t;

  // Encoded as {is_store, funct3}
  typedef enum logic [3:0] {
    LB  = 4'b0000,
    LH  = 4'b0001,
    LW  = 4'b0010,
    LBU = 4'b0100,
    LHU = 4'b0101,
    SB  = 4'b1000,
    SH  = 4'b1001,
    SW  = 4'b1010
  } mem_op_t;

  typedef enum logic [1:0] {
    A_RS1,
    A_PC,
    A_ZERO
  } a_sel_t;

  typedef enum logic {
    B_RS2,
    B_IMM
  } b_sel_t;

  typedef enum logic [1:0] {
    IMM_I,
    IMM_S,
    IMM_U,
    IMM_J
  } imm_kind_t;

  // Op, ports A/B, jump, base, offset, link, wen, rd
  localparam int ARITH_W = $bits(alu_op_t) + 5 * $bits(word_t) + 2 + $bits(reg_idx_t);
  // Op, two operands, rd
  localparam int MULDIV_W = $bits(md_op_t) + 2 * $bits(word_t) + $bits(reg_idx_t);
  // Op, base, offset, store data, rd
  localparam int LS_W = $bits(mem_op_t) + 3 * $bits(word_t) + $bits(reg_idx_t);

endpackage

// File: source/decode_stage.sv
//////////////////////////////
// Decode stage top level
// Decoder, operand builder and
// three unit issue registers
//////////////////////////////

module decode_stage import decode_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  word_t    instr,
  input  word_t    pc,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  logic     pc_en,
  input  logic     flush,
  input  logic     stall_arith,
  input  logic     stall_muldiv,
  input  logic     stall_ls,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output logic     arith_start,
  output alu_op_t  arith_op,
  output word_t    arith_a,
  output word_t    arith_b,
  output logic     arith_jump,
  output word_t    arith_j_base,
  output word_t    arith_j_offset,
  output word_t    arith_link,
  output logic     arith_wen,
  output reg_idx_t arith_rd,
  output logic     md_start,
  output md_op_t   md_op,
  output word_t    md_a,
  output word_t    md_b,
  output reg_idx_t md_rd,
  output logic     ls_start,
  output mem_op_t  ls_op,
  output word_t    ls_base,
  output word_t    ls_offset,
  output word_t    ls_store_data,
  output reg_idx_t ls_rd
);

  fu_t       fu;
  alu_op_t   alu_op;
  md_op_t    dec_md_op;
  mem_op_t   mem_op;
  a_sel_t    a_sel;
  b_sel_t    b_sel;
  imm_kind_t imm_kind;
  logic      jump;
  logic      jump_reg;
  logic      wen;
  reg_idx_t  rd;
  word_t     port_a;
  word_t     port_b;
  word_t     imm;
  word_t     j_base;
  word_t     j_offset;
  word_t     link_data;

  logic [ARITH_W-1:0]  arith_in;
  logic [ARITH_W-1:0]  arith_q;
  logic [MULDIV_W-1:0] md_in;
  logic [MULDIV_W-1:0] md_q;
  logic [LS_W-1:0]     ls_in;
  logic [LS_W-1:0]     ls_q;
  logic [$bits(alu_op_t)-1:0] arith_op_q;
  logic [$bits(md_op_t)-1:0]  md_op_q;
  logic [$bits(mem_op_t)-1:0] ls_op_q;

  instr_decoder decoder_i (
    .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .fu(fu), .alu_op(alu_op),
    .md_op(dec_md_op), .mem_op(mem_op), .a_sel(a_sel), .b_sel(b_sel),
    .imm_kind(imm_kind), .jump(jump), .jump_reg(jump_reg), .wen(wen)
  );

  operand_builder operands_i (
    .instr(instr), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .a_sel(a_sel), .b_sel(b_sel), .imm_kind(imm_kind), .jump_reg(jump_reg),
    .port_a(port_a), .port_b(port_b), .imm(imm), .j_base(j_base),
    .j_offset(j_offset), .link_data(link_data)
  );

  // Stores never reach the arithmetic unit, so wen passes straight through
  assign arith_in = {alu_op, port_a, port_b, jump, j_base, j_offset, link_data, wen, rd};
  assign md_in    = {dec_md_op, rs1_data, rs2_data, rd};
  // imm is already the S form for stores and the I form for loads
  assign ls_in    = {mem_op, rs1_data, imm, rs2_data, rd};

  issue_register #(.W(ARITH_W)) arith_issue (
    .CLK(CLK), .nRST(nRST), .pc_en(pc_en), .flush(flush), .stall(stall_arith),
    .start_in(fu == FU_ARITH), .payload_in(arith_in),
    .start(arith_start), .payload(arith_q)
  );

  issue_register #(.W(MULDIV_W)) muldiv_issue (
    .CLK(CLK), .nRST(nRST), .pc_en(pc_en), .flush(flush), .stall(stall_muldiv),
    .start_in(fu == FU_MULDIV), .payload_in(md_in),
    .start(md_start), .payload(md_q)
  );

  issue_register #(.W(LS_W)) ls_issue (
    .CLK(CLK), .nRST(nRST), .pc_en(pc_en), .flush(flush), .stall(stall_ls),
    .start_in(fu == FU_LS), .payload_in(ls_in),
    .start(ls_start), .payload(ls_q)
  );

  // Unpack registered payloads
  assign {arith_op_q, arith_a, arith_b, arith_jump, arith_j_base, arith_j_offset,
          arith_link, arith_wen, arith_rd} = arith_q;
  assign {md_op_q, md_a, md_b, md_rd} = md_q;
  assign {ls_op_q, ls_base, ls_offset, ls_store_data, ls_rd} = ls_q;

  assign arith_op = alu_op_t'(arith_op_q);
  assign md_op    = md_op_t'(md_op_q);
  assign ls_op    = mem_op_t'(ls_op_q);

endmodule

// File: source/instr_decoder.sv
//////////////////////////////
// Instruction decoder
// Register indices, target unit,
// operation and operand selects
//////////////////////////////

module instr_decoder import decode_pkg::*; (
  input  word_t     instr,
  output reg_idx_t  rs1,
  output reg_idx_t  rs2,
  output reg_idx_t  rd,
  output fu_t       fu,
  output alu_op_t   alu_op,
  output md_op_t    md_op,
  output mem_op_t   mem_op,
  output a_sel_t    a_sel,
  output b_sel_t    b_sel,
  output imm_kind_t imm_kind,
  output logic      jump,
  output logic      jump_reg,
  output logic      wen
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt_op;
  alu_op_t    f3_alu_op;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  // Bit 30 of the word
  assign alt_op = funct7[5];

  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd  = instr[11:7];

  assign md_op  = md_op_t'(funct3);
  assign mem_op = mem_op_t'({opcode == STORE, funct3});

  // Every kept opcode except STORE writes a register
  assign wen = opcode inside {OP, OP_IMM, LUI, AUIPC, JAL, JALR, LOAD};

  // ALU op from funct3 and bit 30
  // SUB only exists in the register form
  always_comb begin
    case (funct3)
      3'b000:  f3_alu_op = (opcode == OP && alt_op) ? SUB : ADD;
      3'b001:  f3_alu_op = SLL;
      3'b010:  f3_alu_op = SLT;
      3'b011:  f3_alu_op = SLTU;
      3'b100:  f3_alu_op = XOR;
      3'b101:  f3_alu_op = alt_op ? SRA : SRL;
      3'b110:  f3_alu_op = OR;
      default: f3_alu_op = AND;
    endcase
  end

  always_comb begin
    fu       = FU_NONE;
    alu_op   = ADD;
    a_sel    = A_RS1;
    b_sel    = B_RS2;
    imm_kind = IMM_I;
    jump     = 1'b0;
    jump_reg = 1'b0;
    case (opcode)
      OP: begin
        // funct7 of 1 marks the M extension
        fu     = (funct7 == 7'b0000001) ? FU_MULDIV : FU_ARITH;
        alu_op = f3_alu_op;
      end
      OP_IMM: begin
        fu     = FU_ARITH;
        alu_op = f3_alu_op;
        b_sel  = B_IMM;
      end
      LUI: begin
        fu       = FU_ARITH;
        a_sel    = A_ZERO;
        b_sel    = B_IMM;
        imm_kind = IMM_U;
      end
      AUIPC: begin
        fu       = FU_ARITH;
        a_sel    = A_PC;
        b_sel    = B_IMM;
        imm_kind = IMM_U;
      end
      JAL: begin
        fu       = FU_ARITH;
        a_sel    = A_PC;
        b_sel    = B_IMM;
        imm_kind = IMM_J;
        jump     = 1'b1;
      end
      JALR: begin
        fu       = FU_ARITH;
        b_sel    = B_IMM;
        jump     = 1'b1;
        jump_reg = 1'b1;
      end
      LOAD: begin
        fu    = FU_LS;
        b_sel = B_IMM;
      end
      STORE: begin
        fu       = FU_LS;
        b_sel    = B_IMM;
        imm_kind = IMM_S;
      end
      default: begin
        // Unknown opcode, nothing issued
        fu = FU_NONE;
      end
    endcase
  end

  // An instruction that reaches no unit must not write back
  always_comb begin
    assert (fu != FU_NONE || !wen)
      else $error("instr_decoder: write enable without a target unit");
  end

endmodule

// File: source/issue_register.sv
//////////////////////////////
// Issue register for one unit
// Clear, load and hold control
//////////////////////////////

module issue_register #(
  parameter int W = 32
) (
  input  logic         CLK,
  input  logic         nRST,
  input  logic         pc_en,
  input  logic         flush,
  input  logic         stall,
  input  logic         start_in,
  input  logic [W-1:0] payload_in,
  output logic         start,
  output logic [W-1:0] payload
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      start   <= 1'b0;
      payload <= '0;
    end else if (pc_en) begin
      if (flush || stall) begin
        // Insert a bubble
        start   <= 1'b0;
        payload <= '0;
      end else begin
        start   <= start_in;
        payload <= payload_in;
      end
    end
  end

  // A cleared slot is empty on the following cycle
  assert property (@(posedge CLK) disable iff (!nRST)
    (pc_en && (flush || stall)) |=> (!start && payload == '0))
    else $error("issue_register: slot not empty after clear");

endmodule

// File: source/operand_builder.sv
//////////////////////////////
// Operand builder
// Immediates, ALU port muxes,
// jump base/offset and link data
//////////////////////////////

module operand_builder import decode_pkg::*; (
  input  word_t     instr,
  input  word_t     pc,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  input  a_sel_t    a_sel,
  input  b_sel_t    b_sel,
  input  imm_kind_t imm_kind,
  input  logic      jump_reg,
  output word_t     port_a,
  output word_t     port_b,
  output word_t     imm,
  output word_t     j_base,
  output word_t     j_offset,
  output word_t     link_data
);

  word_t imm_i;
  word_t imm_s;
  word_t imm_u;
  word_t imm_j;

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (imm_kind)
      IMM_S:   imm = imm_s;
      IMM_U:   imm = imm_u;
      IMM_J:   imm = imm_j;
      default: imm = imm_i;
    endcase
  end

  always_comb begin
    case (a_sel)
      A_PC:    port_a = pc;
      A_ZERO:  port_a = '0;
      default: port_a = rs1_data;
    endcase
  end

  // Shift immediates carry shamt in the low five bits of imm_i
  assign port_b = (b_sel == B_IMM) ? imm : rs2_data;

  // JALR jumps from rs1, JAL from the PC
  assign j_base    = jump_reg ? rs1_data : pc;
  assign j_offset  = jump_reg ? imm_i : imm_j;
  assign link_data = pc + 32'd4;

endmodule
